/* verilog.f */
+incdir+.
valu_pkg.sv
valu_decode_stage.sv
valu_adder.sv
valu_shifter.sv
valu_minmax.sv
valu_execute_stage.sv
valu_top.sv
tb_clock_gen.sv
tb_valu.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_valu -f verilog.f -o tb_valu_sim

output=$(./obj_dir/tb_valu_sim)
echo "$output"

if echo "$output" | grep -qx "Result: PASSED"; then
    exit 0
else
    exit 1
fi

/* tb_valu.sv */
`timescale 1ns/1ps
`include "valu_cfg.svh"

module tb_valu;
    import valu_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int NUM_OPS      = 13;

    typedef struct packed {
        vop_e  op;
        vsew_e sew;
        vreg_t first;
        vreg_t second;
        vreg_t expected;
    } row_t;

    logic  clk;
    logic  reset_n;
    vreg_t first_operand;
    vreg_t second_operand;
    vop_e  vector_operation;
    vsew_e vsew;
    vreg_t result;

    row_t  rows[$];
    int    seed;
    int    cycle_count;
    int    checks_run;
    int    value_errors;
    int    timeout_errors;

    tb_clock_gen u_clock_gen (
        .clk_o     (clk),
        .reset_n_o (reset_n)
    );

    valu_top DUT (
        .clk                (clk),
        .reset_n            (reset_n),
        .first_operand_i    (first_operand),
        .second_operand_i   (second_operand),
        .vector_operation_i (vector_operation),
        .vsew_i             (vsew),
        .result_o           (result)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Works lane by lane on zero-extended 64-bit copies of each element
    function automatic vreg_t model_result(vop_e op, vsew_e sew, vreg_t a, vreg_t b);
        int                 w;
        int                 lanes;
        int                 sh;
        logic [63:0]        mask;
        logic [63:0]        ea;
        logic [63:0]        eb;
        logic [63:0]        er;
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        vreg_t              res;
        case (op)
            vand:    return a & b;
            vor:     return a | b;
            vxor:    return a ^ b;
            default: ;
        endcase
        w     = (sew == EW8) ? 8 : ((sew == EW16) ? 16 : 32);
        lanes = `VALU_VLEN / w;
        mask  = (64'd1 << w) - 64'd1;
        res   = '0;
        for (int k = 0; k < lanes; k++) begin
            ea = (a >> (k * w)) & mask;
            eb = (b >> (k * w)) & mask;
            sa = ea[w-1] ? (ea | ~mask) : ea;
            sb = eb[w-1] ? (eb | ~mask) : eb;
            // Only log2(w) bits of the shift element count
            sh = int'(eb[4:0]) % w;
            case (op)
                vadd:    er = ea + eb;
                vsub:    er = ea - eb;
                vrsub:   er = eb - ea;
                vsll:    er = ea << sh;
                vsrl:    er = ea >> sh;
                vsra:    er = sa >>> sh;
                vmin:    er = (sa < sb) ? ea : eb;
                vmax:    er = (sa > sb) ? ea : eb;
                vminu:   er = (ea < eb) ? ea : eb;
                vmaxu:   er = (ea > eb) ? ea : eb;
                default: er = '0;
            endcase
            res = res | ((er & mask) << (k * w));
        end
        return res;
    endfunction

    task automatic add_row(input vop_e op, input vsew_e sew, input vreg_t a, input vreg_t b);
        row_t r;
        r.op       = op;
        r.sew      = sew;
        r.first    = a;
        r.second   = b;
        r.expected = model_result(op, sew, a, b);
        rows.push_back(r);
    endtask

    task automatic build_table();
        int    idx;
        vreg_t a;
        vreg_t b;
        // Fixed corner cases
        add_row(vand, EW8, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00);
        add_row(vor, EW16, 64'h0123_4567_89AB_CDEF, 64'hFEDC_BA98_7654_3210);
        add_row(vxor, EW32, 64'hAAAA_AAAA_5555_5555, 64'hFFFF_FFFF_FFFF_FFFF);
        // All ones plus one wraps to zero in every lane
        add_row(vadd, EW8, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0101_0101_0101_0101);
        add_row(vadd, EW16, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0001_0001_0001_0001);
        add_row(vadd, EW32, 64'hFFFF_FFFF_FFFF_FFFF, 64'h0000_0001_0000_0001);
        add_row(vsub, EW8, 64'h0000_0000_0000_0000, 64'h0101_0101_0101_0101);
        add_row(vsub, EW16, 64'h0000_0000_0000_0000, 64'h0001_0001_0001_0001);
        add_row(vsub, EW32, 64'h0000_0000_0000_0000, 64'h0000_0001_0000_0001);
        add_row(vrsub, EW8, 64'h0101_0101_0101_0101, 64'h0000_0000_0000_0000);
        add_row(vrsub, EW32, 64'h0000_0005_0000_0003, 64'h0000_0002_0000_0010);
        // Shift amounts with high bits set that must be ignored
        add_row(vsll, EW8, 64'h8181_8181_8181_8181, 64'h0909_0909_0909_0909);
        add_row(vsrl, EW8, 64'h8080_8080_8080_8080, 64'h0F0F_0F0F_0F0F_0F0F);
        add_row(vsra, EW8, 64'h8080_8080_8080_8080, 64'h0F0F_0F0F_0F0F_0F0F);
        add_row(vsra, EW16, 64'h8000_7FF0_8000_7FF0, 64'h0014_0014_0014_0014);
        add_row(vsrl, EW32, 64'h8000_0000_8000_0000, 64'h0000_0021_0000_0021);
        add_row(vsra, EW32, 64'h8000_0000_8000_0000, 64'h0000_0021_0000_0021);
        add_row(vsll, EW32, 64'h0000_0001_0000_0003, 64'h0000_003F_0000_0020);
        // Sign bit set so signed and unsigned answers differ
        add_row(vmin, EW8, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        add_row(vminu, EW8, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        add_row(vmax, EW8, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        add_row(vmaxu, EW8, 64'h8080_8080_8080_8080, 64'h0101_0101_0101_0101);
        add_row(vmin, EW16, 64'h8000_0001_FFFF_7FFF, 64'h0001_8000_0000_8000);
        add_row(vmaxu, EW32, 64'h8000_0000_0000_0001, 64'h7FFF_FFFF_FFFF_FFFF);
        // Every op at every width with the width changing on each row
        for (int o = 0; o < NUM_OPS; o++) begin
            for (int s = 0; s < 3; s++) begin
                a = {$random(seed), $random(seed)};
                b = {$random(seed), $random(seed)};
                add_row(vop_e'(o[3:0]), vsew_e'(s[1:0]), a, b);
            end
        end
        // Mixed order
        for (int n = 0; n < 24; n++) begin
            idx = $unsigned($random(seed)) % NUM_OPS;
            a   = {$random(seed), $random(seed)};
            b   = {$random(seed), $random(seed)};
            add_row(vop_e'(idx[3:0]), vsew_e'(n % 3), a, b);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Drive and compare
    ////////////////////////////////////////////////////////////////////////////

    task automatic drive_row(input row_t r);
        first_operand    = r.first;
        second_operand   = r.second;
        vector_operation = r.op;
        vsew             = r.sew;
    endtask

    task automatic check_result(input vreg_t expected, input vreg_t actual, input string what);
        checks_run++;
        if (actual !== expected) begin
            value_errors++;
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic report_and_finish();
        $display("Checks run: %0d, value errors: %0d, timeouts: %0d",
                 checks_run, value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    // Watchdog sized from the table
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= rows.size() + RESET_CYCLES + 10) begin
            timeout_errors++;
            $display("Timeout: run did not finish within %0d clock cycles", cycle_count);
            report_and_finish();
        end
    end

    initial begin
        row_t r;
        first_operand    = '0;
        second_operand   = '0;
        vector_operation = vand;
        vsew             = EW8;
        seed             = 93849;
        cycle_count      = 0;
        checks_run       = 0;
        value_errors     = 0;
        timeout_errors   = 0;
        build_table();

        @(posedge clk);
        #1;
        check_result('0, result, "result during reset");
        wait (reset_n === 1'b1);

        // Row i goes in now and is checked two clocks later
        for (int i = 0; i < rows.size() + 2; i++) begin
            @(posedge clk);
            #1;
            if (i < 2) begin
                check_result('0, result, "result before first operation");
            end else begin
                r = rows[i-2];
                check_result(r.expected, result,
                             $sformatf("row %0d %s %s", i - 2, r.op.name(), r.sew.name()));
            end
            if (i < rows.size()) begin
                drive_row(rows[i]);
            end
        end
        report_and_finish();
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic reset_n_o
);
    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 3;

    // 20 ns period
    initial begin
        clk_o = 1'b0;
    end

    always #HALF_PERIOD clk_o = ~clk_o;

    // Release lands just after an edge like the stimulus
    initial begin
        reset_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        reset_n_o = 1'b1;
    end

endmodule

/* valu_top.sv */
`timescale 1ns/1ps

module valu_top (
    input  logic            clk,
    input  logic            reset_n,

    input  valu_pkg::vreg_t first_operand_i,
    input  valu_pkg::vreg_t second_operand_i,
    input  valu_pkg::vop_e  vector_operation_i,
    input  valu_pkg::vsew_e vsew_i,

    output valu_pkg::vreg_t result_o
);
    import valu_pkg::*;

    // Decode to execute payload
    alu_stage_t stage;

    valu_decode_stage u_decode (
        .clk                (clk),
        .reset_n            (reset_n),
        .first_operand_i    (first_operand_i),
        .second_operand_i   (second_operand_i),
        .vector_operation_i (vector_operation_i),
        .vsew_i             (vsew_i),
        .stage_o            (stage)
    );

    valu_execute_stage u_execute (
        .clk      (clk),
        .reset_n  (reset_n),
        .stage_i  (stage),
        .result_o (result_o)
    );

endmodule

/* valu_execute_stage.sv */
`timescale 1ns/1ps

module valu_execute_stage (
    input  logic                 clk,
    input  logic                 reset_n,
    input  valu_pkg::alu_stage_t stage_i,
    output valu_pkg::vreg_t      result_o
);
    import valu_pkg::*;

    vreg_t result_and;
    vreg_t result_or;
    vreg_t result_xor;
    vreg_t result_add;
    vreg_t result_sll;
    vreg_t result_srl;
    vreg_t result_sra;
    vreg_t result_min;
    vreg_t result_minu;
    vreg_t result_max;
    vreg_t result_maxu;
    vreg_t result_next;

    ////////////////////////////////////////////////////////////////////////
    // Functional units
    ////////////////////////////////////////////////////////////////////////

    // Logical ops ignore element width
    assign result_and = stage_i.first_operand & stage_i.second_operand;
    assign result_or  = stage_i.first_operand | stage_i.second_operand;
    assign result_xor = stage_i.first_operand ^ stage_i.second_operand;

    valu_adder u_adder (
        .first_operand_i  (stage_i.first_operand),
        .second_operand_i (stage_i.second_operand),
        .subtract_i       (stage_i.ctrl.subtract),
        .swap_i           (stage_i.ctrl.swap),
        .vsew_i           (stage_i.ctrl.vsew),
        .sum_o            (result_add)
    );

    valu_shifter u_shifter (
        .first_operand_i  (stage_i.first_operand),
        .second_operand_i (stage_i.second_operand),
        .vsew_i           (stage_i.ctrl.vsew),
        .sll_o            (result_sll),
        .srl_o            (result_srl),
        .sra_o            (result_sra)
    );

    valu_minmax u_minmax (
        .first_operand_i  (stage_i.first_operand),
        .second_operand_i (stage_i.second_operand),
        .vsew_i           (stage_i.ctrl.vsew),
        .min_o            (result_min),
        .minu_o           (result_minu),
        .max_o            (result_max),
        .maxu_o           (result_maxu)
    );

    ////////////////////////////////////////////////////////////////////////
    // Result select and register
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (stage_i.ctrl.res_sel)
            RES_AND:  result_next = result_and;
            RES_OR:   result_next = result_or;
            RES_XOR:  result_next = result_xor;
            RES_SLL:  result_next = result_sll;
            RES_SRL:  result_next = result_srl;
            RES_SRA:  result_next = result_sra;
            RES_MIN:  result_next = result_min;
            RES_MINU: result_next = result_minu;
            RES_MAX:  result_next = result_max;
            RES_MAXU: result_next = result_maxu;
            default:  result_next = result_add;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            result_o <= '0;
        else
            result_o <= result_next;
    end

endmodule

/* valu_minmax.sv */
`timescale 1ns/1ps
`include "valu_cfg.svh"

module valu_minmax (
    input  valu_pkg::vreg_t first_operand_i,
    input  valu_pkg::vreg_t second_operand_i,
    input  valu_pkg::vsew_e vsew_i,
    output valu_pkg::vreg_t min_o,
    output valu_pkg::vreg_t minu_o,
    output valu_pkg::vreg_t max_o,
    output valu_pkg::vreg_t maxu_o
);
    import valu_pkg::*;

    // Ties keep the first operand for min and the second for max
    always_comb begin
        case (vsew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    automatic elem8_t a8;
                    automatic elem8_t b8;
                    automatic logic   gt_u;
                    automatic logic   gt_s;
                    a8   = first_operand_i[i*`VALU_EW8 +: `VALU_EW8];
                    b8   = second_operand_i[i*`VALU_EW8 +: `VALU_EW8];
                    gt_u = a8 > b8;
                    gt_s = $signed(a8) > $signed(b8);
                    minu_o[i*`VALU_EW8 +: `VALU_EW8] = gt_u ? b8 : a8;
                    min_o[i*`VALU_EW8 +: `VALU_EW8]  = gt_s ? b8 : a8;
                    maxu_o[i*`VALU_EW8 +: `VALU_EW8] = gt_u ? a8 : b8;
                    max_o[i*`VALU_EW8 +: `VALU_EW8]  = gt_s ? a8 : b8;
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    automatic elem16_t a16;
                    automatic elem16_t b16;
                    automatic logic    gt_u;
                    automatic logic    gt_s;
                    a16  = first_operand_i[i*`VALU_EW16 +: `VALU_EW16];
                    b16  = second_operand_i[i*`VALU_EW16 +: `VALU_EW16];
                    gt_u = a16 > b16;
                    gt_s = $signed(a16) > $signed(b16);
                    minu_o[i*`VALU_EW16 +: `VALU_EW16] = gt_u ? b16 : a16;
                    min_o[i*`VALU_EW16 +: `VALU_EW16]  = gt_s ? b16 : a16;
                    maxu_o[i*`VALU_EW16 +: `VALU_EW16] = gt_u ? a16 : b16;
                    max_o[i*`VALU_EW16 +: `VALU_EW16]  = gt_s ? a16 : b16;
                end
            end
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    automatic elem32_t a32;
                    automatic elem32_t b32;
                    automatic logic    gt_u;
                    automatic logic    gt_s;
                    a32  = first_operand_i[i*`VALU_EW32 +: `VALU_EW32];
                    b32  = second_operand_i[i*`VALU_EW32 +: `VALU_EW32];
                    gt_u = a32 > b32;
                    gt_s = $signed(a32) > $signed(b32);
                    minu_o[i*`VALU_EW32 +: `VALU_EW32] = gt_u ? b32 : a32;
                    min_o[i*`VALU_EW32 +: `VALU_EW32]  = gt_s ? b32 : a32;
                    maxu_o[i*`VALU_EW32 +: `VALU_EW32] = gt_u ? a32 : b32;
                    max_o[i*`VALU_EW32 +: `VALU_EW32]  = gt_s ? a32 : b32;
                end
            end
        endcase
    end

endmodule

/* valu_shifter.sv */
`timescale 1ns/1ps
`include "valu_cfg.svh"

module valu_shifter (
    input  valu_pkg::vreg_t first_operand_i,
    input  valu_pkg::vreg_t second_operand_i,
    input  valu_pkg::vsew_e vsew_i,
    output valu_pkg::vreg_t sll_o,
    output valu_pkg::vreg_t srl_o,
    output valu_pkg::vreg_t sra_o
);
    import valu_pkg::*;

    // Shift amount is the low log2(width) bits of each second operand element
    always_comb begin
        case (vsew_i)
            EW8: begin
                for (int i = 0; i < `VALU_LANES8; i++) begin
                    automatic elem8_t                       a8;
                    automatic logic [$clog2(`VALU_EW8)-1:0] sh8;
                    a8  = first_operand_i[i*`VALU_EW8 +: `VALU_EW8];
                    sh8 = second_operand_i[i*`VALU_EW8 +: $clog2(`VALU_EW8)];
                    sll_o[i*`VALU_EW8 +: `VALU_EW8] = a8 << sh8;
                    srl_o[i*`VALU_EW8 +: `VALU_EW8] = a8 >> sh8;
                    sra_o[i*`VALU_EW8 +: `VALU_EW8] = $signed(a8) >>> sh8;
                end
            end
            EW16: begin
                for (int i = 0; i < `VALU_LANES16; i++) begin
                    automatic elem16_t                       a16;
                    automatic logic [$clog2(`VALU_EW16)-1:0] sh16;
                    a16  = first_operand_i[i*`VALU_EW16 +: `VALU_EW16];
                    sh16 = second_operand_i[i*`VALU_EW16 +: $clog2(`VALU_EW16)];
                    sll_o[i*`VALU_EW16 +: `VALU_EW16] = a16 << sh16;
                    srl_o[i*`VALU_EW16 +: `VALU_EW16] = a16 >> sh16;
                    sra_o[i*`VALU_EW16 +: `VALU_EW16] = $signed(a16) >>> sh16;
                end
            end
            // 32 bits and also the unused encoding
            default: begin
                for (int i = 0; i < `VALU_LANES32; i++) begin
                    automatic elem32_t                       a32;
                    automatic logic [$clog2(`VALU_EW32)-1:0] sh32;
                    a32  = first_operand_i[i*`VALU_EW32 +: `VALU_EW32];
                    sh32 = second_operand_i[i*`VALU_EW32 +: $clog2(`VALU_EW32)];
                    sll_o[i*`VALU_EW32 +: `VALU_EW32] = a32 << sh32;
                    srl_o[i*`VALU_EW32 +: `VALU_EW32] = a32 >> sh32;
                    sra_o[i*`VALU_EW32 +: `VALU_EW32] = $signed(a32) >>> sh32;
                end
            end
        endcase
    end

endmodule

/* valu_adder.sv */
`timescale 1ns/1ps
`include "valu_cfg.svh"

module valu_adder (
    input  valu_pkg::vreg_t first_operand_i,
    input  valu_pkg::vreg_t second_operand_i,
    input  logic            subtract_i,
    input  logic            swap_i,
    input  valu_pkg::vsew_e vsew_i,
    output valu_pkg::vreg_t sum_o
);
    import valu_pkg::*;

    vreg_t addend_a;
    vreg_t addend_b;
    vreg_t sum_8;
    vreg_t sum_16;
    vreg_t sum_32;

    // Reverse subtract uses the first operand as subtrahend
    assign addend_a = swap_i ? second_operand_i : first_operand_i;
    assign addend_b = swap_i ? first_operand_i : second_operand_i;

    ////////////////////////////////////////////////////////////////////////
    // Per-lane sums with carries kept inside each element
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < `VALU_LANES8; i++) begin
            automatic elem8_t b8;
            b8 = addend_b[i*`VALU_EW8 +: `VALU_EW8];
            if (subtract_i)
                b8 = ~b8 + elem8_t'(1);
            sum_8[i*`VALU_EW8 +: `VALU_EW8] = addend_a[i*`VALU_EW8 +: `VALU_EW8] + b8;
        end
        for (int i = 0; i < `VALU_LANES16; i++) begin
            automatic elem16_t b16;
            b16 = addend_b[i*`VALU_EW16 +: `VALU_EW16];
            if (subtract_i)
                b16 = ~b16 + elem16_t'(1);
            sum_16[i*`VALU_EW16 +: `VALU_EW16] = addend_a[i*`VALU_EW16 +: `VALU_EW16] + b16;
        end
        for (int i = 0; i < `VALU_LANES32; i++) begin
            automatic elem32_t b32;
            b32 = addend_b[i*`VALU_EW32 +: `VALU_EW32];
            if (subtract_i)
                b32 = ~b32 + elem32_t'(1);
            sum_32[i*`VALU_EW32 +: `VALU_EW32] = addend_a[i*`VALU_EW32 +: `VALU_EW32] + b32;
        end
    end

    // Width select
    always_comb begin
        case (vsew_i)
            EW8:     sum_o = sum_8;
            EW16:    sum_o = sum_16;
            default: sum_o = sum_32;
        endcase
    end

endmodule

/* valu_decode_stage.sv */
`timescale 1ns/1ps

module valu_decode_stage (
    input  logic                 clk,
    input  logic                 reset_n,

    input  valu_pkg::vreg_t      first_operand_i,
    input  valu_pkg::vreg_t      second_operand_i,
    input  valu_pkg::vop_e       vector_operation_i,
    input  valu_pkg::vsew_e      vsew_i,

    output valu_pkg::alu_stage_t stage_o
);
    import valu_pkg::*;

    alu_ctrl_t ctrl;

    ////////////////////////////////////////////////////////////////////////
    // Opcode decode
    ////////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl.subtract = 1'b0;
        ctrl.swap     = 1'b0;
        ctrl.vsew     = vsew_i;
        case (vector_operation_i)
            vadd: begin
                ctrl.res_sel = RES_ADD;
            end
            vsub: begin
                ctrl.res_sel  = RES_ADD;
                ctrl.subtract = 1'b1;
            end
            // Second operand minus first
            vrsub: begin
                ctrl.res_sel  = RES_ADD;
                ctrl.subtract = 1'b1;
                ctrl.swap     = 1'b1;
            end
            vand:    ctrl.res_sel = RES_AND;
            vor:     ctrl.res_sel = RES_OR;
            vxor:    ctrl.res_sel = RES_XOR;
            vsll:    ctrl.res_sel = RES_SLL;
            vsrl:    ctrl.res_sel = RES_SRL;
            vsra:    ctrl.res_sel = RES_SRA;
            vmin:    ctrl.res_sel = RES_MIN;
            vminu:   ctrl.res_sel = RES_MINU;
            vmax:    ctrl.res_sel = RES_MAX;
            vmaxu:   ctrl.res_sel = RES_MAXU;
            default: ctrl.res_sel = RES_ADD;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // Stage register
    ////////////////////////////////////////////////////////////////////////

    // Reset state is a vand of zeros so the result stays zero
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            stage_o.ctrl.res_sel  <= RES_AND;
            stage_o.ctrl.subtract <= 1'b0;
            stage_o.ctrl.swap     <= 1'b0;
            stage_o.ctrl.vsew     <= EW8;
            stage_o.first_operand <= '0;
            stage_o.second_operand <= '0;
        end else begin
            stage_o.ctrl           <= ctrl;
            stage_o.first_operand  <= first_operand_i;
            stage_o.second_operand <= second_operand_i;
        end
    end

endmodule

/* valu_pkg.sv */
`include "valu_cfg.svh"

package valu_pkg;

    // Register and element words
    typedef logic [`VALU_VLEN-1:0] vreg_t;
    typedef logic [`VALU_EW8-1:0]  elem8_t;
    typedef logic [`VALU_EW16-1:0] elem16_t;
    typedef logic [`VALU_EW32-1:0] elem32_t;

    // Element width where 2'b11 falls back to 32 bits
    typedef enum logic [1:0] {
        EW8  = 2'b00,
        EW16 = 2'b01,
        EW32 = 2'b10
    } vsew_e;

    typedef enum logic [3:0] {
        vadd, vsub, vrsub,
        vand, vor, vxor,
        vsll, vsrl, vsra,
        vmin, vminu, vmax, vmaxu
    } vop_e;

    // Which unit output gets registered
    typedef enum logic [3:0] {
        RES_ADD, RES_AND, RES_OR, RES_XOR,
        RES_SLL, RES_SRL, RES_SRA,
        RES_MIN, RES_MINU, RES_MAX, RES_MAXU
    } res_sel_e;

    ////////////////////////////////////////////////////////////////////////
    // Pipeline payload
    ////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        res_sel_e res_sel;
        logic     subtract;
        logic     swap;
        vsew_e    vsew;
    } alu_ctrl_t;

    typedef struct packed {
        alu_ctrl_t ctrl;
        vreg_t     first_operand;
        vreg_t     second_operand;
    } alu_stage_t;

endpackage

/* valu_cfg.svh */
`ifndef VALU_CFG_SVH
`define VALU_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Vector register geometry
////////////////////////////////////////////////////////////////////////////

// Full vector register width
`define VALU_VLEN 64

// Element widths selectable by vsew
`define VALU_EW8  8
`define VALU_EW16 16
`define VALU_EW32 32

////////////////////////////////////////////////////////////////////////////
// Lane counts
////////////////////////////////////////////////////////////////////////////

// Elements per register at 8 bits
`define VALU_LANES8  (`VALU_VLEN / `VALU_EW8)

// Elements per register at 16 bits
`define VALU_LANES16 (`VALU_VLEN / `VALU_EW16)

// Elements per register at 32 bits
`define VALU_LANES32 (`VALU_VLEN / `VALU_EW32)

`endif
